// ==== hw/cache_cfg_pkg.sv ====
package cache_cfg_pkg;

   // Front-end word address and data sizes.
   localparam int FE_ADDR_W = 12;
   localparam int DATA_W    = 32;
   localparam int NBYTES    = DATA_W / 8;

   // Four words per line.
   localparam int OFFSET_W  = 2;

   // Word address, index and tag are cut from this.
   typedef logic [FE_ADDR_W-1:0] addr_t;

   typedef logic [DATA_W-1:0]    word_t;

   // All zero marks a read.
   typedef logic [NBYTES-1:0]    wstrb_t;

   typedef logic [OFFSET_W-1:0]  offset_t;

   typedef enum logic [2:0] {
      IDLE,      // Lookup, accepts requests.
      FILL_REQ,  // Issue line reads.
      FILL_WAIT, // Collect last word.
      RESPOND,   // Return missed word.
      WRITE      // Write-through cycle.
   } ctrl_state_t;

endpackage

// ==== hw/cache_bus_pkg.sv ====
package cache_bus_pkg;

   import cache_cfg_pkg::*;

   // Front-end request, held steady while ready is low.
   typedef struct packed {
      logic   valid;
      addr_t  addr;
      word_t  wdata;
      wstrb_t wstrb;
   } fe_req_t;

   // Front-end response, rdata qualified by rvalid.
   typedef struct packed {
      logic   ready;
      logic   rvalid;
      word_t  rdata;
   } fe_rsp_t;

   // Backend request towards the memory.
   typedef struct packed {
      logic   valid;
      addr_t  addr;
      word_t  wdata;
      wstrb_t wstrb;
   } be_req_t;

   // Read data comes back one cycle after the request.
   typedef struct packed {
      logic   ready;
      logic   rvalid;
      word_t  rdata;
   } be_rsp_t;

endpackage

// ==== hw/cache_tag_store.sv ====
`timescale 1ns/10ps

module cache_tag_store
   import cache_cfg_pkg::*;
#(
   parameter  int NLINES_W = 4,
   localparam int TAG_W    = FE_ADDR_W - NLINES_W - OFFSET_W,
   localparam int NLINES   = 2 ** NLINES_W
) (
   input  logic                clk_i,
   input  logic                rst_i,
   input  logic [NLINES_W-1:0] index_i,
   input  logic [TAG_W-1:0]    tag_i,
   input  logic                fill_i,
   input  logic                invalidate_i,
   output logic                hit_o
);

   logic [NLINES-1:0] valid_q;
   logic [TAG_W-1:0]  tag_mem [NLINES];

   // Flash clear of all lines.
   always_ff @(posedge clk_i) begin
      if (rst_i || invalidate_i) begin
         valid_q <= '0;
      end else if (fill_i) begin
         valid_q[index_i] <= 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (fill_i) begin
         tag_mem[index_i] <= tag_i;
      end
   end

   assign hit_o = valid_q[index_i] && (tag_mem[index_i] == tag_i); // Combinational lookup.

   // The controller must never finish a fill while a clear is running.
   a_fill_vs_invalidate: assert property (
      @(posedge clk_i) disable iff (rst_i)
      !(fill_i && invalidate_i)
   ) else $error("tag store: fill and invalidate in the same cycle");

endmodule

// ==== hw/cache_data_store.sv ====
`timescale 1ns/10ps

module cache_data_store
   import cache_cfg_pkg::*;
#(
   parameter  int NLINES_W = 4,
   localparam int DEPTH_W  = NLINES_W + OFFSET_W,
   localparam int DEPTH    = 2 ** DEPTH_W
) (
   input  logic                clk_i,
   input  logic [NLINES_W-1:0] index_i,
   input  offset_t             offset_i,
   input  word_t               wdata_i,
   input  wstrb_t              wstrb_i,
   output word_t               rdata_o
);

   word_t              mem [DEPTH];
   logic [DEPTH_W-1:0] addr;

   assign addr = {index_i, offset_i}; // Line index, then word.

   // Byte-wise merge into the addressed word.
   always_ff @(posedge clk_i) begin
      for (int b = 0; b < NBYTES; b++) begin
         if (wstrb_i[b]) begin
            mem[addr][b*8 +: 8] <= wdata_i[b*8 +: 8];
         end
      end
   end

   assign rdata_o = mem[addr];

endmodule

// ==== hw/cache_ctrl.sv ====
`timescale 1ns/10ps

module cache_ctrl
   import cache_cfg_pkg::*;
   import cache_bus_pkg::*;
#(
   parameter  int NLINES_W = 4,
   localparam int TAG_W    = FE_ADDR_W - NLINES_W - OFFSET_W
) (
   input  logic                clk_i,
   input  logic                rst_i,
   input  fe_req_t             fe_req_i,
   output fe_rsp_t             fe_rsp_o,
   input  logic                invalidate_i,
   output be_req_t             be_req_o,
   input  be_rsp_t             be_rsp_i,
   output logic [NLINES_W-1:0] index_o,
   output logic [TAG_W-1:0]    tag_o,
   input  logic                hit_i,
   output logic                tag_fill_o,
   output offset_t             dat_offset_o,
   output word_t               dat_wdata_o,
   output wstrb_t              dat_wstrb_o,
   input  word_t               dat_rdata_i
);

   localparam int TAG_LSB = OFFSET_W + NLINES_W;

   ctrl_state_t state_q;
   ctrl_state_t state_d;
   fe_req_t     req_q;        // Accepted request.
   offset_t     req_cnt_q;    // Next fill read.
   offset_t     ret_cnt_q;    // Next fill return.
   logic        hit_rvalid_q;
   word_t       hit_rdata_q;
   addr_t       cur_addr;
   logic        ready;
   logic        accept;
   logic        accept_read;
   logic        fill_beat;

   assign ready       = (state_q == IDLE) && !invalidate_i; // No lookup during a clear.
   assign accept      = fe_req_i.valid && ready;
   assign accept_read = accept && (fe_req_i.wstrb == '0);

   // Live address while idle, held copy otherwise.
   assign cur_addr = (state_q == IDLE) ? fe_req_i.addr : req_q.addr;
   assign index_o  = cur_addr[OFFSET_W +: NLINES_W];
   assign tag_o    = cur_addr[TAG_LSB +: TAG_W];

   assign fill_beat = be_rsp_i.rvalid && ((state_q == FILL_REQ) || (state_q == FILL_WAIT));

   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE: begin
            if (accept && (fe_req_i.wstrb != '0)) begin
               state_d = WRITE;
            end else if (accept_read && !hit_i) begin
               state_d = FILL_REQ;
            end
         end
         FILL_REQ: begin
            if (be_rsp_i.ready && (req_cnt_q == '1)) begin
               state_d = FILL_WAIT;
            end
         end
         FILL_WAIT: begin
            if (be_rsp_i.rvalid && (ret_cnt_q == '1)) begin
               state_d = RESPOND;
            end
         end
         RESPOND: begin
            state_d = IDLE;
         end
         WRITE: begin
            if (be_rsp_i.ready) begin
               state_d = IDLE;
            end
         end
         default: begin
            state_d = IDLE;
         end
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q      <= IDLE;
         req_cnt_q    <= '0;
         ret_cnt_q    <= '0;
         hit_rvalid_q <= 1'b0;
      end else begin
         state_q      <= state_d;
         hit_rvalid_q <= accept_read && hit_i;
         if ((state_q == FILL_REQ) && be_rsp_i.ready) begin
            req_cnt_q <= req_cnt_q + 1'b1; // Wraps to zero after the line.
         end
         if (fill_beat) begin
            ret_cnt_q <= ret_cnt_q + 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (accept) begin
         req_q <= fe_req_i;
      end
      if (accept_read && hit_i) begin
         hit_rdata_q <= dat_rdata_i;
      end
   end

   // Fill beats take priority; write-through merges only on a hit.
   always_comb begin
      dat_offset_o = cur_addr[OFFSET_W-1:0];
      dat_wdata_o  = req_q.wdata;
      dat_wstrb_o  = '0;
      if (fill_beat) begin
         dat_offset_o = ret_cnt_q;
         dat_wdata_o  = be_rsp_i.rdata;
         dat_wstrb_o  = '1;
      end else if ((state_q == WRITE) && hit_i) begin
         dat_wstrb_o = req_q.wstrb;
      end
   end

   // Tag set with the last word, dropped if a clear arrived mid-fill.
   assign tag_fill_o = fill_beat && (ret_cnt_q == '1) && !invalidate_i;

   always_comb begin
      be_req_o = '0;
      case (state_q)
         FILL_REQ: begin
            be_req_o.valid = 1'b1;
            be_req_o.addr  = {req_q.addr[FE_ADDR_W-1:OFFSET_W], req_cnt_q};
         end
         WRITE: begin
            be_req_o.valid = 1'b1;
            be_req_o.addr  = req_q.addr;
            be_req_o.wdata = req_q.wdata;
            be_req_o.wstrb = req_q.wstrb;
         end
         default: begin
            be_req_o.valid = 1'b0;
         end
      endcase
   end

   assign fe_rsp_o = '{
      ready:  ready,
      rvalid: hit_rvalid_q || (state_q == RESPOND),
      rdata:  (state_q == RESPOND) ? dat_rdata_i : hit_rdata_q
   };

   // An idle response always belongs to a read hit taken the cycle before.
   a_rvalid_idle: assert property (
      @(posedge clk_i) disable iff (rst_i)
      (state_q == IDLE && fe_rsp_o.rvalid) |-> $past(accept_read)
   ) else $error("cache_ctrl: rvalid in IDLE without an accepted read");

   // Every fill return must be consumed before the response.
   a_no_be_in_respond: assert property (
      @(posedge clk_i) disable iff (rst_i)
      (state_q == RESPOND) |-> (!be_req_o.valid && !be_rsp_i.rvalid)
   ) else $error("cache_ctrl: backend request or return during RESPOND");

endmodule

// ==== hw/cache_top.sv ====
`timescale 1ns/10ps

module cache_top
   import cache_cfg_pkg::*;
   import cache_bus_pkg::*;
#(
   parameter int NLINES_W = 4
) (
   input  logic    clk_i,
   input  logic    rst_i,
   input  fe_req_t fe_req_i,
   output fe_rsp_t fe_rsp_o,
   input  logic    invalidate_i,
   output be_req_t be_req_o,
   input  be_rsp_t be_rsp_i
);

   localparam int TAG_W = FE_ADDR_W - NLINES_W - OFFSET_W;

   logic [NLINES_W-1:0] index;
   logic [TAG_W-1:0]    tag;
   logic                hit;
   logic                tag_fill;
   offset_t             dat_offset;
   word_t               dat_wdata;
   wstrb_t              dat_wstrb;
   word_t               dat_rdata;

   cache_ctrl #(
      .NLINES_W(NLINES_W)
   ) i_ctrl (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .fe_req_i    (fe_req_i),
      .fe_rsp_o    (fe_rsp_o),
      .invalidate_i(invalidate_i),
      .be_req_o    (be_req_o),
      .be_rsp_i    (be_rsp_i),
      .index_o     (index),
      .tag_o       (tag),
      .hit_i       (hit),
      .tag_fill_o  (tag_fill),
      .dat_offset_o(dat_offset),
      .dat_wdata_o (dat_wdata),
      .dat_wstrb_o (dat_wstrb),
      .dat_rdata_i (dat_rdata)
   );

   cache_tag_store #(
      .NLINES_W(NLINES_W)
   ) i_tags (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .index_i     (index),
      .tag_i       (tag),
      .fill_i      (tag_fill),
      .invalidate_i(invalidate_i),
      .hit_o       (hit)
   );

   cache_data_store #(
      .NLINES_W(NLINES_W)
   ) i_data (
      .clk_i   (clk_i),
      .index_i (index),
      .offset_i(dat_offset),
      .wdata_i (dat_wdata),
      .wstrb_i (dat_wstrb),
      .rdata_o (dat_rdata)
   );

endmodule

// ==== hw/be_ram_sp.sv ====
`timescale 1ns/10ps

module be_ram_sp
   import cache_cfg_pkg::*;
   import cache_bus_pkg::*;
(
   input  logic    clk_i,
   input  logic    rst_i,
   input  be_req_t be_req_i,
   output be_rsp_t be_rsp_o
);

   localparam int DEPTH = 2 ** FE_ADDR_W;

   word_t mem [DEPTH];
   word_t rdata_q;
   logic  rvalid_q;
   logic  rd_req;

   assign rd_req = be_req_i.valid && (be_req_i.wstrb == '0);

   always_ff @(posedge clk_i) begin
      if (be_req_i.valid) begin
         for (int b = 0; b < NBYTES; b++) begin
            if (be_req_i.wstrb[b]) begin
               mem[be_req_i.addr][b*8 +: 8] <= be_req_i.wdata[b*8 +: 8];
            end
         end
      end
      if (rd_req) begin
         rdata_q <= mem[be_req_i.addr]; // Registered read port.
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         rvalid_q <= 1'b0;
      end else begin
         rvalid_q <= rd_req;
      end
   end

   assign be_rsp_o = '{ready: 1'b1, rvalid: rvalid_q, rdata: rdata_q}; // Never stalls.

   a_rvalid_after_read: assert property (
      @(posedge clk_i) disable iff (rst_i)
      be_rsp_o.rvalid |-> $past(rd_req)
   ) else $error("be_ram_sp: rvalid without a read in the previous cycle");

endmodule

// ==== hw/cache_sim_wrapper.sv ====
`timescale 1ns/10ps

module cache_sim_wrapper
   import cache_bus_pkg::*;
#(
   parameter int NLINES_W = 4
) (
   input  logic    clk_i,
   input  logic    rst_i,
   input  fe_req_t fe_req_i,
   output fe_rsp_t fe_rsp_o,
   input  logic    invalidate_i
);

   be_req_t be_req;
   be_rsp_t be_rsp;

   cache_top #(
      .NLINES_W(NLINES_W)
   ) i_cache (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .fe_req_i    (fe_req_i),
      .fe_rsp_o    (fe_rsp_o),
      .invalidate_i(invalidate_i),
      .be_req_o    (be_req),
      .be_rsp_i    (be_rsp)
   );

   be_ram_sp i_ram (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .be_req_i(be_req),
      .be_rsp_o(be_rsp)
   );

endmodule

// ==== bench/cache_tb.sv ====
`timescale 1ns/10ps

module cache_tb
   import cache_cfg_pkg::*;
   import cache_bus_pkg::*;
();

   localparam int NLINES_W = 4;
   localparam int NBASES   = 6;
   localparam int NADDR    = NBASES * 4;
   localparam int N_HIT    = 60;
   localparam int N_MIX    = 120;
   localparam int N_INV    = 40;
   localparam int N_REQ    = NADDR + 2 * N_HIT + N_MIX + 2 * N_INV;
   localparam int LIMIT    = 20 * N_REQ + 100; // Reset and idle cycles fit in the margin.

   logic    clk_i;
   logic    rst_i;
   fe_req_t fe_req;
   fe_rsp_t fe_rsp;
   logic    invalidate;
   logic    expect_hit;   // Marks the request on the bus as a hit probe.

   addr_t   addr_set [NADDR];
   word_t   model [addr_t];
   word_t   exp_q [$];
   logic    hit_due;
   addr_t   hit_addr;
   int      errors;
   int      rd_acc_cnt;
   int      wr_acc_cnt;
   int      rvalid_cnt;
   int      cycle_cnt;

   cache_sim_wrapper #(
      .NLINES_W(NLINES_W)
   ) i_dut (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .fe_req_i    (fe_req),
      .fe_rsp_o    (fe_rsp),
      .invalidate_i(invalidate)
   );

   initial begin
      clk_i = 1'b0;
      forever #4 clk_i = ~clk_i;
   end

   function automatic word_t merge_bytes(input word_t old_w, input word_t new_w, input wstrb_t s);
      word_t res;
      res = old_w;
      for (int b = 0; b < NBYTES; b++) begin
         if (s[b]) begin
            res[b*8 +: 8] = new_w[b*8 +: 8];
         end
      end
      return res;
   endfunction

   // Starts and ends at a falling edge; holds the request until accepted.
   task automatic issue(input addr_t a, input word_t d, input wstrb_t s, input logic probe);
      fe_req.valid = 1'b1;
      fe_req.addr  = a;
      fe_req.wdata = d;
      fe_req.wstrb = s;
      expect_hit   = probe;
      @(posedge clk_i);
      while (!fe_rsp.ready) begin
         @(posedge clk_i);
      end
      @(negedge clk_i);
      fe_req.valid = 1'b0;
      expect_hit   = 1'b0;
   endtask

   task automatic wait_reads_done();
      while (exp_q.size() != 0) begin
         @(negedge clk_i);
      end
   endtask

   task automatic pulse_invalidate();
      invalidate = 1'b1;
      @(negedge clk_i);
      invalidate = 1'b0;
   endtask

   function automatic addr_t pick_addr();
      return addr_set[$urandom_range(NADDR - 1)];
   endfunction

   task automatic finish_run();
      $display("reads %0d, writes %0d, rvalid pulses %0d, errors %0d",
               rd_acc_cnt, wr_acc_cnt, rvalid_cnt, errors);
      if (errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   endtask

   // Samples at the rising edge, before the DUT registers update.
   always @(posedge clk_i) begin : monitor
      logic  acc;
      word_t exp_word;
      if (rst_i) begin
         hit_due = 1'b0;
      end else begin
         if (hit_due) begin
            a_hit_latency: assert (fe_rsp.rvalid) else begin
               errors++;
               $display("read of 0x%h to a cached line gave no rvalid in the next cycle",
                        hit_addr);
            end
         end
         if (fe_rsp.rvalid) begin
            rvalid_cnt++;
            a_rvalid_matched: assert (exp_q.size() > 0) else begin
               errors++;
               $display("rvalid seen with no accepted read outstanding");
            end
            if (exp_q.size() > 0) begin
               exp_word = exp_q.pop_front();
               a_rdata: assert (fe_rsp.rdata === exp_word) else begin
                  errors++;
                  $display("[ERROR] fe_rsp_o.rdata expected 0x%h actual 0x%h",
                           exp_word, fe_rsp.rdata);
               end
            end
         end
         acc     = fe_req.valid && fe_rsp.ready;
         hit_due = acc && (fe_req.wstrb == '0) && expect_hit;
         if (acc && (fe_req.wstrb == '0)) begin
            rd_acc_cnt++;
            exp_q.push_back(model[fe_req.addr]);
            hit_addr = fe_req.addr;
         end else if (acc) begin
            wr_acc_cnt++;
            model[fe_req.addr] = merge_bytes(model[fe_req.addr], fe_req.wdata, fe_req.wstrb);
         end
      end
   end

   initial begin
      cycle_cnt = 0;
      while (cycle_cnt < LIMIT) begin
         @(posedge clk_i);
         cycle_cnt++;
      end
      errors++;
      $display("run stopped at the cycle limit of %0d", LIMIT);
      finish_run();
   end

   initial begin : stimulus
      addr_t bases [NBASES];
      addr_t a;
      rst_i       = 1'b1;
      fe_req      = '0;
      invalidate  = 1'b0;
      expect_hit  = 1'b0;
      hit_due     = 1'b0;
      errors      = 0;
      rd_acc_cnt  = 0;
      wr_acc_cnt  = 0;
      rvalid_cnt  = 0;
      void'($urandom(48138));
      // Index 0 three times, index 5 twice, index 14 once.
      bases = '{12'h000, 12'h040, 12'h080, 12'h014, 12'h054, 12'h3F8};
      for (int i = 0; i < NBASES; i++) begin
         for (int o = 0; o < 4; o++) begin
            addr_set[i*4 + o] = bases[i] | addr_t'(o);
         end
      end

      repeat (10) @(negedge clk_i);
      rst_i = 1'b0;
      @(posedge clk_i);
      a_ready_after_reset: assert (fe_rsp.ready) else begin
         errors++;
         $display("ready is low after reset");
      end
      a_rvalid_after_reset: assert (!fe_rsp.rvalid) else begin
         errors++;
         $display("rvalid is high after reset");
      end
      @(negedge clk_i);

      // Full words first, so no read sees unknown bytes.
      for (int i = 0; i < NADDR; i++) begin
         issue(addr_set[i], $urandom, 4'hF, 1'b0);
      end

      // A completed read leaves its line cached for the next one.
      for (int i = 0; i < N_HIT; i++) begin
         a = pick_addr();
         issue(a, '0, '0, 1'b0);
         wait_reads_done();
         a[OFFSET_W-1:0] = offset_t'($urandom_range(3));
         issue(a, '0, '0, 1'b1);
         wait_reads_done();
      end

      // Partial writes mixed with reads, hits and misses alike.
      for (int i = 0; i < N_MIX; i++) begin
         a = pick_addr();
         if ($urandom_range(1) == 1) begin
            issue(a, $urandom, wstrb_t'($urandom_range(15, 1)), 1'b0);
         end else begin
            issue(a, '0, '0, 1'b0);
         end
      end
      wait_reads_done();

      // Clears land between requests and during fills.
      for (int i = 0; i < N_INV; i++) begin
         a = pick_addr();
         issue(a, '0, '0, 1'b0);
         if ($urandom_range(1) == 1) begin
            pulse_invalidate();
         end
         if ($urandom_range(3) == 0) begin
            issue(a, $urandom, wstrb_t'($urandom_range(15, 1)), 1'b0);
         end else begin
            issue(a, '0, '0, 1'b0);
         end
      end
      wait_reads_done();
      repeat (4) @(negedge clk_i);

      a_rvalid_count: assert (rvalid_cnt == rd_acc_cnt) else begin
         errors++;
         $display("%0d rvalid pulses for %0d accepted reads", rvalid_cnt, rd_acc_cnt);
      end
      finish_run();
   end

endmodule

// ==== verilog.f ====
hw/cache_cfg_pkg.sv
hw/cache_bus_pkg.sv
hw/cache_tag_store.sv
hw/cache_data_store.sv
hw/cache_ctrl.sv
hw/cache_top.sv
hw/be_ram_sp.sv
hw/cache_sim_wrapper.sv
bench/cache_tb.sv
